// File: design/rv_alu.sv
`timescale 1ns/10ps

module rv_alu (
    input  rv_pkg::alu_op_e         op,
    input  logic [rv_pkg::xlen-1:0] a,
    input  logic [rv_pkg::xlen-1:0] b,
    output logic [rv_pkg::xlen-1:0] result
);
    import rv_pkg::*;

    logic [4:0] shamt;

    // only the low five bits shift
    assign shamt = b[4:0];

    always_comb begin
        case (op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_sll:    result = a << shamt;
            alu_slt:    result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu:   result = {{(xlen-1){1'b0}}, a < b};
            alu_xor:    result = a ^ b;
            alu_srl:    result = a >> shamt;
            alu_sra:    result = $unsigned($signed(a) >>> shamt);
            alu_or:     result = a | b;
            alu_and:    result = a & b;
            // lui
            alu_pass_b: result = b;
            default:    result = '0;
        endcase
    end

endmodule

// File: design/rv_core.sv
`timescale 1ns/10ps

module rv_core (
    input  logic          clk,
    input  logic          rst_n,
    input  rv_pkg::prog_t prog,
    output rv_pkg::wb_t   retire
);
    import rv_pkg::*;

    f2d_t               fetch_to_decode;
    d2x_t               decode_to_execute;
    x2w_t               execute_to_wb;
    redirect_t          jal_redirect;
    redirect_t          x_redirect;
    wb_t                wb;
    logic [reg_aw-1:0]  rs1_addr;
    logic [reg_aw-1:0]  rs2_addr;
    logic [xlen-1:0]    rs1_data;
    logic [xlen-1:0]    rs2_data;
    logic [dmem_aw-1:0] dmem_addr;
    logic               dmem_we;
    logic [xlen-1:0]    dmem_wdata;
    logic [xlen-1:0]    dmem_rdata;

    rv_fetch i_rv_fetch (
        .clk          (clk),
        .rst_n        (rst_n),
        .prog         (prog),
        .jal_redirect (jal_redirect),
        .x_redirect   (x_redirect),
        .fetch_out    (fetch_to_decode)
    );

    rv_decode i_rv_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_in     (fetch_to_decode),
        .x_redirect   (x_redirect),
        .wb           (wb),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .jal_redirect (jal_redirect),
        .decode_out   (decode_to_execute)
    );

    rv_regfile i_rv_regfile (
        .clk      (clk),
        .wb       (wb),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    rv_execute i_rv_execute (
        .clk        (clk),
        .rst_n      (rst_n),
        .decode_in  (decode_to_execute),
        .wb         (wb),
        .dmem_addr  (dmem_addr),
        .dmem_we    (dmem_we),
        .dmem_wdata (dmem_wdata),
        .x_redirect (x_redirect),
        .x_out      (execute_to_wb)
    );

    rv_data_mem i_rv_data_mem (
        .clk   (clk),
        .addr  (dmem_addr),
        .we    (dmem_we),
        .wdata (dmem_wdata),
        .rdata (dmem_rdata)
    );

    rv_writeback i_rv_writeback (
        .x_in       (execute_to_wb),
        .dmem_rdata (dmem_rdata),
        .wb         (wb)
    );

    assign retire = wb;

endmodule

// File: design/rv_data_mem.sv
`timescale 1ns/10ps

module rv_data_mem (
    input  logic                       clk,
    input  logic [rv_pkg::dmem_aw-1:0] addr,
    input  logic                       we,
    input  logic [rv_pkg::xlen-1:0]    wdata,
    output logic [rv_pkg::xlen-1:0]    rdata
);
    import rv_pkg::*;

    logic [xlen-1:0] mem [dmem_words];

    // read returns the old word when the same address is written
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

// File: design/rv_decode.sv
`timescale 1ns/10ps

module rv_decode (
    input  logic                     clk,
    input  logic                     rst_n,
    input  rv_pkg::f2d_t             fetch_in,
    input  rv_pkg::redirect_t        x_redirect,
    input  rv_pkg::wb_t              wb,
    output logic [rv_pkg::reg_aw-1:0] rs1_addr,
    output logic [rv_pkg::reg_aw-1:0] rs2_addr,
    input  logic [rv_pkg::xlen-1:0]   rs1_data,
    input  logic [rv_pkg::xlen-1:0]   rs2_data,
    output rv_pkg::redirect_t        jal_redirect,
    output rv_pkg::d2x_t             decode_out
);
    import rv_pkg::*;

    logic [xlen-1:0] inst_d;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    logic [xlen-1:0] imm_j;
    d2x_t            decode_q;

    // wrong-path instruction behind a taken branch or jalr
    assign inst_d = x_redirect.taken ? nop_inst : fetch_in.inst;

    assign rs1_addr = inst_d[19:15];
    assign rs2_addr = inst_d[24:20];

    // value retiring this cycle is not yet in the register file
    assign rs1_val = (wb.valid && wb.rd == rs1_addr) ? wb.data : rs1_data;
    assign rs2_val = (wb.valid && wb.rd == rs2_addr) ? wb.data : rs2_data;

    assign imm_j = {{12{inst_d[31]}}, inst_d[19:12], inst_d[20], inst_d[30:21], 1'b0};

    assign jal_redirect.taken  = (inst_d[6:0] == opc_jal);
    assign jal_redirect.target = fetch_in.pc + imm_j;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            decode_q <= '{pc: reset_pc, inst: nop_inst, rs1_val: '0, rs2_val: '0};
        end else begin
            decode_q.pc      <= fetch_in.pc;
            decode_q.inst    <= inst_d;
            decode_q.rs1_val <= rs1_val;
            decode_q.rs2_val <= rs2_val;
        end
    end

    assign decode_out = decode_q;

endmodule

// File: design/rv_execute.sv
`timescale 1ns/10ps

module rv_execute (
    input  logic                       clk,
    input  logic                       rst_n,
    input  rv_pkg::d2x_t               decode_in,
    input  rv_pkg::wb_t                wb,
    output logic [rv_pkg::dmem_aw-1:0] dmem_addr,
    output logic                       dmem_we,
    output logic [rv_pkg::xlen-1:0]    dmem_wdata,
    output rv_pkg::redirect_t          x_redirect,
    output rv_pkg::x2w_t               x_out
);
    import rv_pkg::*;

    logic [xlen-1:0]   inst;
    opcode_e           opcode;
    logic [2:0]        funct3;
    logic [reg_aw-1:0] rd;
    logic [xlen-1:0]   imm;
    logic [xlen-1:0]   rs1_fwd;
    logic [xlen-1:0]   rs2_fwd;
    logic [xlen-1:0]   alu_a;
    logic [xlen-1:0]   alu_b;
    logic [xlen-1:0]   alu_res;
    alu_op_e           alu_op;
    logic              cond;
    logic              writes_rd;
    x2w_t              x_q;

    assign inst   = decode_in.inst;
    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign rd     = inst[11:7];

    always_comb begin
        case (opcode)
            opc_op_imm, opc_load, opc_jalr:
                imm = {{20{inst[31]}}, inst[31:20]};
            opc_store:
                imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            opc_branch:
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            opc_lui, opc_auipc:
                imm = {inst[31:12], 12'b0};
            opc_jal:
                imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default:
                imm = '0;
        endcase
    end

    // W stage result, load data included
    assign rs1_fwd = (wb.valid && wb.rd == inst[19:15]) ? wb.data : decode_in.rs1_val;
    assign rs2_fwd = (wb.valid && wb.rd == inst[24:20]) ? wb.data : decode_in.rs2_val;

    // pc-relative forms put the pc on port a
    assign alu_a = (opcode == opc_auipc || opcode == opc_branch || opcode == opc_jal) ?
                   decode_in.pc : rs1_fwd;
    assign alu_b = (opcode == opc_op) ? rs2_fwd : imm;

    always_comb begin
        alu_op = alu_add;
        if (opcode == opc_lui) begin
            alu_op = alu_pass_b;
        end else if (opcode == opc_op || opcode == opc_op_imm) begin
            case (funct3)
                3'b000: alu_op = (opcode == opc_op && inst[30]) ? alu_sub : alu_add;
                3'b001: alu_op = alu_sll;
                3'b010: alu_op = alu_slt;
                3'b011: alu_op = alu_sltu;
                3'b100: alu_op = alu_xor;
                3'b101: alu_op = inst[30] ? alu_sra : alu_srl;
                3'b110: alu_op = alu_or;
                default: alu_op = alu_and;
            endcase
        end
    end

    rv_alu i_rv_alu (
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_res)
    );

    always_comb begin
        case (funct3)
            3'b000: cond = (rs1_fwd == rs2_fwd);
            3'b001: cond = (rs1_fwd != rs2_fwd);
            3'b100: cond = ($signed(rs1_fwd) < $signed(rs2_fwd));
            3'b101: cond = ($signed(rs1_fwd) >= $signed(rs2_fwd));
            3'b110: cond = (rs1_fwd < rs2_fwd);
            3'b111: cond = (rs1_fwd >= rs2_fwd);
            default: cond = 1'b0;
        endcase
    end

    // alu holds pc+imm for branches and rs1+imm for jalr
    assign x_redirect.taken  = (opcode == opc_branch && cond) || (opcode == opc_jalr);
    assign x_redirect.target = {alu_res[xlen-1:1], 1'b0};

    assign dmem_addr  = alu_res[dmem_aw+1:2];
    assign dmem_we    = (opcode == opc_store);
    assign dmem_wdata = rs2_fwd;

    assign writes_rd = (opcode == opc_op) || (opcode == opc_op_imm) || (opcode == opc_lui) ||
                       (opcode == opc_auipc) || (opcode == opc_load) ||
                       (opcode == opc_jal) || (opcode == opc_jalr);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            x_q <= '0;
        end else begin
            x_q.we      <= writes_rd;
            x_q.rd      <= rd;
            x_q.alu_res <= alu_res;
            x_q.pc      <= decode_in.pc;
            if (opcode == opc_load) begin
                x_q.kind <= res_load;
            end else if (opcode == opc_jal || opcode == opc_jalr) begin
                x_q.kind <= res_link;
            end else begin
                x_q.kind <= res_alu;
            end
        end
    end

    assign x_out = x_q;

    // a store never shows up as a register write one cycle later
    assert property (@(posedge clk) disable iff (!rst_n)
                     dmem_we |-> (opcode == opc_store) ##1 !x_out.we)
        else $error("data memory write from a non-store instruction");

endmodule

// File: design/rv_fetch.sv
`timescale 1ns/10ps

module rv_fetch (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::prog_t     prog,
    input  rv_pkg::redirect_t jal_redirect,
    input  rv_pkg::redirect_t x_redirect,
    output rv_pkg::f2d_t      fetch_out
);
    import rv_pkg::*;

    logic [xlen-1:0]    pc_q;
    logic [xlen-1:0]    next_pc;
    logic [imem_aw-1:0] rd_addr;
    logic [xlen-1:0]    inst_q;
    logic [xlen-1:0]    imem [imem_words];

    // execute redirect wins over jal from decode
    always_comb begin
        if (!rst_n) begin
            next_pc = reset_pc;
        end else if (x_redirect.taken) begin
            next_pc = x_redirect.target;
        end else if (jal_redirect.taken) begin
            next_pc = jal_redirect.target;
        end else begin
            next_pc = pc_q + xlen'(4);
        end
    end

    assign rd_addr = next_pc[imem_aw+1:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= reset_pc;
        end else begin
            pc_q <= next_pc;
        end
    end

    // read at next pc so the word lines up with pc_q
    always_ff @(posedge clk) begin
        if (prog.we) begin
            imem[prog.addr] <= prog.data;
        end
        if (prog.we && prog.addr == rd_addr) begin
            inst_q <= prog.data;
        end else begin
            inst_q <= imem[rd_addr];
        end
    end

    assign fetch_out = '{pc: pc_q, inst: inst_q};

    // program loading only happens under reset
    assert property (@(posedge clk) rst_n |-> !prog.we)
        else $error("instruction memory written while core is running");

endmodule

// File: design/rv_pkg.sv
package rv_pkg;

    // datapath and memory sizes
    localparam int xlen       = 32;
    localparam int imem_words = 1024;
    localparam int dmem_words = 1024;
    localparam int imem_aw    = 10;
    localparam int dmem_aw    = 10;
    localparam int reg_aw     = 5;

    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

    // addi x0, x0, 0
    localparam logic [xlen-1:0] nop_inst = 32'h0000_0013;

    // writeback source select
    localparam logic [1:0] res_alu  = 2'd0;
    localparam logic [1:0] res_load = 2'd1;
    localparam logic [1:0] res_link = 2'd2;

    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        alu_pass_b = 4'd10
    } alu_op_e;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
    } f2d_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
        logic [xlen-1:0] rs1_val;
        logic [xlen-1:0] rs2_val;
    } d2x_t;

    typedef struct packed {
        logic              we;
        logic [reg_aw-1:0] rd;
        logic [1:0]        kind;
        logic [xlen-1:0]   alu_res;
        logic [xlen-1:0]   pc;
    } x2w_t;

    typedef struct packed {
        logic            taken;
        logic [xlen-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic              valid;
        logic [reg_aw-1:0] rd;
        logic [xlen-1:0]   data;
    } wb_t;

    typedef struct packed {
        logic               we;
        logic [imem_aw-1:0] addr;
        logic [xlen-1:0]    data;
    } prog_t;

endpackage

// File: design/rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile (
    input  logic                      clk,
    input  rv_pkg::wb_t               wb,
    input  logic [rv_pkg::reg_aw-1:0] rs1_addr,
    input  logic [rv_pkg::reg_aw-1:0] rs2_addr,
    output logic [rv_pkg::xlen-1:0]   rs1_data,
    output logic [rv_pkg::xlen-1:0]   rs2_data
);
    import rv_pkg::*;

    // x0 has no storage
    logic [xlen-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (wb.valid && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    // a read of x0 returns zero on either port
    assert property (@(posedge clk) (rs1_addr == '0) |-> (rs1_data == '0))
        else $error("x0 read back nonzero on the rs1 port");
    assert property (@(posedge clk) (rs2_addr == '0) |-> (rs2_data == '0))
        else $error("x0 read back nonzero on the rs2 port");

endmodule

// File: design/rv_writeback.sv
`timescale 1ns/10ps

module rv_writeback (
    input  rv_pkg::x2w_t            x_in,
    input  logic [rv_pkg::xlen-1:0] dmem_rdata,
    output rv_pkg::wb_t             wb
);
    import rv_pkg::*;

    logic [xlen-1:0] wb_data;
    logic [xlen-1:0] link_addr;

    // return address for jal and jalr
    assign link_addr = x_in.pc + xlen'(4);

    always_comb begin
        case (x_in.kind)
            res_load: wb_data = dmem_rdata;
            res_link: wb_data = link_addr;
            default:  wb_data = x_in.alu_res;
        endcase
    end

    // x0 writes are dropped here, so nothing downstream sees them
    assign wb.valid = x_in.we && (x_in.rd != '0);
    assign wb.rd    = x_in.rd;
    assign wb.data  = wb_data;

endmodule

// File: flist.f
design/rv_pkg.sv
design/rv_alu.sv
design/rv_regfile.sv
design/rv_data_mem.sv
design/rv_fetch.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_writeback.sv
design/rv_core.sv
verification/tb_rv_core.sv

// File: verification/tb_rv_core.sv
`timescale 1ns/10ps

module tb_rv_core;
    import rv_pkg::*;

    localparam int reset_cycles = 10;
    localparam int quiet_cycles = 20;
    localparam logic [31:0] self_loop = 32'h0000_006f;

    logic        clk;
    logic        rst_n;
    prog_t       prog;
    wb_t         retire;
    logic [31:0] prog_words[$];
    wb_t         expected[$];
    int          exp_idx = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    string       test_name = "none";

    rv_core i_rv_core (
        .clk    (clk),
        .rst_n  (rst_n),
        .prog   (prog),
        .retire (retire)
    );

    always #10 clk = ~clk;

    // instruction encoders
    function automatic logic [31:0] rtype(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3,
                                          int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), opc_op};
    endfunction

    function automatic logic [31:0] itype(logic [11:0] imm, int rs1, logic [2:0] f3, int rd,
                                          logic [6:0] op);
        return {imm, 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic logic [31:0] stype(logic [11:0] imm, int rs2, int rs1);
        return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], opc_store};
    endfunction

    function automatic logic [31:0] btype(logic [2:0] f3, int rs1, int rs2, int off);
        logic [12:0] o;
        o = 13'(off);
        return {o[12], o[10:5], 5'(rs2), 5'(rs1), f3, o[4:1], o[11], opc_branch};
    endfunction

    function automatic logic [31:0] utype(logic [6:0] op, int rd, logic [19:0] imm);
        return {imm, 5'(rd), op};
    endfunction

    function automatic logic [31:0] jtype(int rd, int off);
        logic [20:0] o;
        o = 21'(off);
        return {o[20], o[10:1], o[11], o[19:12], 5'(rd), opc_jal};
    endfunction

    // lui plus addi, with the upper part rounded for the sign of the low part
    function automatic void load_const(int rd, logic [31:0] value);
        logic [31:0] upper;
        upper = value + 32'h800;
        prog_words.push_back(utype(opc_lui, rd, upper[31:12]));
        prog_words.push_back(itype(value[11:0], rd, 3'd0, rd, opc_op_imm));
    endfunction

    // every program starts by giving all registers a known value
    function automatic void init_regs();
        for (int r = 1; r < 32; r++) begin
            load_const(r, $urandom());
        end
    endfunction

    // ISA reference for OP and OP_IMM
    function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic [31:0] a,
                                            logic [31:0] b);
        logic signed [31:0] sa;
        sa = a;
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return {31'b0, sa < $signed(b)};
            3'b011: return {31'b0, a < b};
            3'b100: return a ^ b;
            3'b101: begin
                if (alt) begin
                    return sa >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            3'b000: return a == b;
            3'b001: return a != b;
            3'b100: return $signed(a) < $signed(b);
            3'b101: return $signed(a) >= $signed(b);
            3'b110: return a < b;
            default: return a >= b;
        endcase
    endfunction

    // architectural run of prog_words, fills expected and returns the dynamic length
    function automatic int run_model();
        logic [31:0] regs [32];
        logic [31:0] mem [dmem_words];
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] addr;
        logic [31:0] res;
        logic [31:0] next_pc;
        logic        writes;
        int          steps;
        regs = '{default: '0};
        expected.delete();
        pc = 0;
        steps = 0;
        while (prog_words[pc[31:2]] != self_loop && steps < 20000) begin
            inst = prog_words[pc[31:2]];
            a = regs[inst[19:15]];
            b = regs[inst[24:20]];
            imm_i = {{20{inst[31]}}, inst[31:20]};
            res = '0;
            writes = 1'b1;
            next_pc = pc + 4;
            case (inst[6:0])
                opc_lui:    res = {inst[31:12], 12'b0};
                opc_auipc:  res = pc + {inst[31:12], 12'b0};
                opc_op:     res = alu_ref(inst[14:12], inst[30], a, b);
                opc_op_imm: res = alu_ref(inst[14:12], inst[30] && inst[14:12] == 3'b101,
                                          a, imm_i);
                opc_load: begin
                    addr = a + imm_i;
                    res = mem[addr[11:2]];
                end
                opc_store: begin
                    addr = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
                    mem[addr[11:2]] = b;
                    writes = 1'b0;
                end
                opc_branch: begin
                    writes = 1'b0;
                    if (branch_ref(inst[14:12], a, b)) begin
                        next_pc = pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                                        inst[11:8], 1'b0};
                    end
                end
                opc_jal: begin
                    res = pc + 4;
                    next_pc = pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                                    inst[30:21], 1'b0};
                end
                opc_jalr: begin
                    res = pc + 4;
                    next_pc = (a + imm_i) & ~32'd1;
                end
                default: writes = 1'b0;
            endcase
            if (writes && inst[11:7] != 5'd0) begin
                regs[inst[11:7]] = res;
                expected.push_back('{valid: 1'b1, rd: inst[11:7], data: res});
            end
            pc = next_pc;
            steps++;
        end
        return steps + 1;
    endfunction

    task automatic compare(string what, logic [31:0] exp_val, logic [31:0] act_val);
        if (act_val !== exp_val) begin
            $display("CHECK FAILED %s: %s expected %h actual %h",
                     test_name, what, exp_val, act_val);
            $display("Test failed");
            $fatal(1, "retire mismatch");
        end
    endtask

    // each retired write against the next write of the model
    always @(negedge clk) begin
        if (rst_n && retire.valid) begin
            if (exp_idx >= expected.size()) begin
                $display("%s: write to x%0d retired after the last expected write",
                         test_name, retire.rd);
                $display("Test failed");
                $fatal(1, "unexpected write");
            end else begin
                compare("rd", 32'(expected[exp_idx].rd), 32'(retire.rd));
                compare("data", expected[exp_idx].data, retire.data);
                exp_idx++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout in %s after %0d cycles", test_name, cycle_limit);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    // reset, load through the program port, release and wait for all writes
    task automatic run_test(string name);
        int len;
        test_name = name;
        rst_n = 1'b0;
        len = run_model();
        exp_idx = 0;
        cycle_limit += 4 * len + prog_words.size() + reset_cycles + quiet_cycles;
        foreach (prog_words[i]) begin
            prog = '{we: 1'b1, addr: imem_aw'(i), data: prog_words[i]};
            @(posedge clk);
            #1;
        end
        prog = '0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
        while (exp_idx < expected.size()) @(posedge clk);
        repeat (quiet_cycles) @(posedge clk);
        #1;
    endtask

    function automatic void build_alu_program();
        int          rd;
        int          rs1;
        int          rs2;
        int          f3;
        logic        alt;
        logic [11:0] imm;
        prog_words.delete();
        init_regs();
        // small register window so back-to-back dependencies are common
        repeat (200) begin
            rd = $urandom_range(7);
            rs1 = $urandom_range(7);
            rs2 = $urandom_range(7);
            f3 = $urandom_range(7);
            alt = (f3 == 0 || f3 == 5) && $urandom_range(1);
            imm = 12'($urandom());
            case ($urandom_range(3))
                0: prog_words.push_back(rtype({1'b0, alt, 5'b0}, rs2, rs1, 3'(f3), rd));
                1: begin
                    if (f3 == 1 || f3 == 5) begin
                        imm = {1'b0, alt, 5'b0, imm[4:0]};
                    end
                    prog_words.push_back(itype(imm, rs1, 3'(f3), rd, opc_op_imm));
                end
                2: prog_words.push_back(utype(opc_lui, rd, 20'($urandom())));
                default: prog_words.push_back(utype(opc_auipc, rd, 20'($urandom())));
            endcase
        end
        prog_words.push_back(jtype(0, 0));
    endfunction

    function automatic void build_mem_program();
        int rd;
        prog_words.delete();
        init_regs();
        load_const(1, 32'h0000_0200);
        // store then load the same word, used at once
        prog_words.push_back(stype(12'd0, 2, 1));
        prog_words.push_back(itype(12'd0, 1, 3'b010, 3, opc_load));
        prog_words.push_back(rtype(7'd0, 3, 3, 3'd0, 4));
        prog_words.push_back(stype(12'd4, 4, 1));
        prog_words.push_back(itype(12'd4, 1, 3'b010, 5, opc_load));
        prog_words.push_back(stype(12'd8, 5, 1));
        prog_words.push_back(itype(12'd0, 1, 3'b010, 6, opc_load));
        prog_words.push_back(itype(12'd8, 1, 3'b010, 7, opc_load));
        for (int k = 0; k < 16; k++) begin
            prog_words.push_back(stype(12'(4 * k - 32), $urandom_range(31), 1));
        end
        repeat (24) begin
            rd = $urandom_range(31, 2);
            prog_words.push_back(itype(12'(4 * $urandom_range(15) - 32), 1, 3'b010, rd,
                                       opc_load));
            if ($urandom_range(1)) begin
                prog_words.push_back(rtype(7'd0, rd, rd, 3'd0, $urandom_range(31, 2)));
            end else begin
                prog_words.push_back(stype(12'(4 * $urandom_range(15) - 32), rd, 1));
            end
        end
        prog_words.push_back(jtype(0, 0));
    endfunction

    function automatic void build_branch_program();
        logic [31:0] edges [5] = '{32'h0, 32'h1, 32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff};
        logic [2:0]  conds [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        prog_words.delete();
        init_regs();
        foreach (edges[i]) begin
            foreach (edges[j]) begin
                load_const(1, edges[i]);
                load_const(2, edges[j]);
                foreach (conds[c]) begin
                    // taken skips the write to x3
                    prog_words.push_back(btype(conds[c], 1, 2, 8));
                    prog_words.push_back(itype(12'(c + 1), 0, 3'd0, 3, opc_op_imm));
                    prog_words.push_back(itype(12'd1, 4, 3'd0, 4, opc_op_imm));
                end
            end
        end
        // short backward loop
        load_const(5, 32'd3);
        prog_words.push_back(itype(12'hfff, 5, 3'd0, 5, opc_op_imm));
        prog_words.push_back(btype(3'b001, 5, 0, -4));
        prog_words.push_back(jtype(0, 0));
    endfunction

    function automatic void build_jump_program();
        prog_words.delete();
        init_regs();
        // call, callee, return, then jump over the callee
        prog_words.push_back(jtype(1, 12));
        prog_words.push_back(itype(12'd7, 5, 3'd0, 5, opc_op_imm));
        prog_words.push_back(jtype(0, 12));
        prog_words.push_back(itype(12'd9, 6, 3'd0, 6, opc_op_imm));
        prog_words.push_back(itype(12'd0, 1, 3'd0, 0, opc_jalr));
        prog_words.push_back(utype(opc_auipc, 7, 20'd0));
        prog_words.push_back(itype(12'd12, 7, 3'd0, 8, opc_jalr));
        prog_words.push_back(itype(12'd1, 0, 3'd0, 9, opc_op_imm));
        prog_words.push_back(rtype(7'd0, 0, 8, 3'd0, 11));
        prog_words.push_back(jtype(12, 4));
        prog_words.push_back(jtype(0, 0));
    endfunction

    function automatic void build_x0_program();
        prog_words.delete();
        init_regs();
        prog_words.push_back(itype(12'd5, 1, 3'd0, 0, opc_op_imm));
        prog_words.push_back(rtype(7'd0, 0, 0, 3'd0, 2));
        prog_words.push_back(utype(opc_lui, 0, 20'h12345));
        prog_words.push_back(itype(12'hfff, 0, 3'd0, 3, opc_op_imm));
        prog_words.push_back(rtype(7'd0, 0, 3, 3'd0, 0));
        prog_words.push_back(rtype(7'd0, 3, 0, 3'd0, 4));
        repeat (30) begin
            prog_words.push_back(rtype(7'd0, $urandom_range(31), $urandom_range(31), 3'd4, 0));
            prog_words.push_back(rtype(7'd0, 0, $urandom_range(31), 3'd6,
                                       $urandom_range(31, 1)));
        end
        prog_words.push_back(jtype(0, 0));
    endfunction

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        prog = '0;
        void'($urandom(75));
        build_alu_program();
        run_test("random_alu");
        build_mem_program();
        run_test("load_store");
        build_branch_program();
        run_test("branches");
        build_jump_program();
        run_test("jal_jalr");
        build_x0_program();
        run_test("x0_writes");
        $display("Test passed");
        $finish;
    end

endmodule
